// ==== common/tqv_periph_pkg.sv ====
/*
 * Shared types for the peripheral wrapper.
 * Vector typedefs, access-size codes, slot numbers,
 * GPIO and register bank offsets, bus request and response structs.
 */
package tqv_periph_pkg;

    typedef logic [10:0] addr_t;     // Peripheral address
    typedef logic [31:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  slot_t;
    typedef logic [15:0] slot_sel_t; // One-hot slot select
    typedef logic [1:0]  acc_n_t;    // Active-low access size
    typedef logic [4:0]  func_sel_t; // Bit 4 picks a simple slot
    typedef logic [13:0] irq_vec_t;  // User interrupts 2 to 15

    // Access size codes from the core
    localparam acc_n_t ACC_BYTE = 2'b00;
    localparam acc_n_t ACC_HALF = 2'b01;
    localparam acc_n_t ACC_WORD = 2'b10;
    localparam acc_n_t ACC_NONE = 2'b11;

    // Fixed slot positions
    localparam slot_t SLOT_GPIO    = 4'd1;
    localparam slot_t SLOT_REGBANK = 4'd15;
    localparam slot_t SIMPLE_PWM   = 4'd5;

    localparam func_sel_t FUNC_GPIO = 5'd1; // Pin routing after reset

    // GPIO register offsets within the user slot
    localparam logic [5:0] GPIO_OUT_OFS   = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS    = 6'h04;
    localparam logic [5:0] GPIO_AUDIO_OFS = 6'h10;
    localparam logic [5:0] GPIO_FSEL_BASE = 6'h20; // One word per pin

    // Register bank offsets
    localparam logic [5:0] RB_REG0_OFS   = 6'h00;
    localparam logic [5:0] RB_REG1_OFS   = 6'h04;
    localparam logic [5:0] RB_STATUS_OFS = 6'h08;

    // Request from the core, 47 bits
    typedef struct packed {
        addr_t  addr;
        data_t  wdata;
        acc_n_t write_n;
        acc_n_t read_n;
    } bus_req_t;

    // Response of one slot, 33 bits
    typedef struct packed {
        data_t data;
        logic  ready;
    } peri_rsp_t;

    typedef peri_rsp_t [15:0] user_rsp_t;
    typedef byte_t [15:0]     simple_data_t;
    typedef byte_t [15:0]     pin_src_t;    // Pin outputs, one byte per slot

endpackage

// ==== hw/gpio/gpio_ctrl.sv ====
/*
 * GPIO block.
 * Output register, input readback, per-pin function select,
 * output pin routing and audio select.
 */
`timescale 1ns/1ps

module gpio_ctrl
    import tqv_periph_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  addr_t    i_addr,
    input  data_t    i_wdata,
    input  logic     i_wr,
    input  byte_t    i_ui_in,
    input  pin_src_t i_user_pins,
    input  pin_src_t i_simple_pins,
    output data_t    o_rdata,
    output byte_t    o_uo_out,
    output logic     o_audio_select
);

    byte_t           gpio_out;
    func_sel_t [7:0] func_sel;
    logic [2:0]      audio_sel;
    logic [5:0]      ofs;
    logic [5:0]      fsel_ofs;
    logic            fsel_hit;
    logic [2:0]      fsel_pin;
    pin_src_t        user_src;

    assign ofs      = i_addr[5:0];
    assign fsel_ofs = ofs - GPIO_FSEL_BASE;
    // One word aligned register per pin above the base
    assign fsel_hit = (ofs >= GPIO_FSEL_BASE) && (fsel_ofs[1:0] == 2'b00);
    assign fsel_pin = fsel_ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
            func_sel  <= {8{FUNC_GPIO}};     // Every pin starts as GPIO
        end else if (i_wr) begin
            if (ofs == GPIO_OUT_OFS) gpio_out <= i_wdata[7:0];
            if (ofs == GPIO_AUDIO_OFS) audio_sel <= i_wdata[2:0];
            if (fsel_hit) func_sel[fsel_pin] <= i_wdata[4:0];
        end
    end

    always_comb begin
        o_rdata = '0;
        if (ofs == GPIO_OUT_OFS) begin
            o_rdata = {24'h0, gpio_out};
        end else if (ofs == GPIO_IN_OFS) begin
            o_rdata = {24'h0, i_ui_in};
        end else if (ofs == GPIO_AUDIO_OFS) begin
            o_rdata = {29'h0, audio_sel};
        end else if (fsel_hit) begin
            o_rdata = {27'h0, func_sel[fsel_pin]};
        end
    end

    // The GPIO slot's own pin byte is the output register
    always_comb begin
        user_src = i_user_pins;
        user_src[SLOT_GPIO] = gpio_out;
    end

    for (genvar i = 0; i < 8; i++) begin : g_pin
        // Pin i takes bit i of the byte from the chosen slot
        assign o_uo_out[i] = func_sel[i][4] ? i_simple_pins[func_sel[i][3:0]][i]
                                            : user_src[func_sel[i][3:0]][i];
    end

    assign o_audio_select = audio_sel[2];

endmodule

// ==== hw/peri_bus/peri_addr_decode.sv ====
/*
 * Slot decode for user and simple slots.
 * Per-slot write and read strobes, response mux.
 */
`timescale 1ns/1ps

module peri_addr_decode
    import tqv_periph_pkg::*;
(
    input  bus_req_t     i_req,
    input  logic         i_read_mask,
    input  user_rsp_t    i_user_rsp,
    input  simple_data_t i_simple_data,
    output slot_sel_t    o_user_wr,
    output slot_sel_t    o_user_rd,
    output slot_sel_t    o_simple_wr,
    output peri_rsp_t    o_rsp
);

    slot_t     user_idx;
    slot_t     simple_idx;
    slot_sel_t user_sel;
    slot_sel_t simple_sel;
    logic      wr_req;
    logic      rd_req;

    assign user_idx   = i_req.addr[9:6];  // 64-byte user slots
    assign simple_idx = i_req.addr[7:4];  // 16-byte simple slots

    assign wr_req = i_req.write_n != ACC_NONE;
    // No new read while the previous result is still held
    assign rd_req = (i_req.read_n != ACC_NONE) && !i_read_mask;

    always_comb begin
        user_sel   = '0;
        simple_sel = '0;
        if (i_req.addr[10]) begin
            simple_sel[simple_idx] = 1'b1;
            o_rsp.data  = {24'h0, i_simple_data[simple_idx]};
            o_rsp.ready = 1'b1;                 // Simple slots never stall
        end else begin
            user_sel[user_idx] = 1'b1;
            o_rsp = i_user_rsp[user_idx];
        end
    end

    assign o_user_wr   = user_sel & {16{wr_req}};
    assign o_user_rd   = user_sel & {16{rd_req}};
    assign o_simple_wr = simple_sel & {16{wr_req}};

endmodule

// ==== hw/peri_bus/peri_read_hold.sv ====
/*
 * Read data register held until the core completes the read.
 * Registered ready, read mask, write ready.
 */
`timescale 1ns/1ps

module peri_read_hold
    import tqv_periph_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  acc_n_t    i_read_n,
    input  acc_n_t    i_write_n,
    input  peri_rsp_t i_rsp,
    input  logic      i_read_complete,
    output data_t     o_data,
    output logic      o_ready,
    output logic      o_read_mask
);

    data_t data_r;
    logic  hold;
    logic  ready_r;
    logic  read_req;
    logic  capture;

    assign read_req = i_read_n != ACC_NONE;
    assign capture  = read_req && i_rsp.ready && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) hold <= 1'b0;
            if (capture) hold <= 1'b1;          // A new capture wins over complete
            ready_r <= read_req && i_rsp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) data_r <= i_rsp.data;
    end

    assign o_data      = data_r;
    assign o_ready     = ready_r || (i_write_n != ACC_NONE);
    assign o_read_mask = ready_r;

endmodule

// ==== hw/pwm_audio.sv ====
/*
 * PWM audio source for a simple slot.
 * Level register and free-running 8-bit counter.
 */
`timescale 1ns/1ps

module pwm_audio
    import tqv_periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] i_addr,
    input  byte_t      i_wdata,
    input  logic       i_wr,
    output byte_t      o_rdata,
    output byte_t      o_pins
);

    byte_t level;
    byte_t count;
    logic  pwm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level <= '0;                     // Silent after reset
            count <= '0;
        end else begin
            count <= count + 8'd1;           // Wraps every 256 cycles
            if (i_wr && i_addr == 4'h0) level <= i_wdata;
        end
    end

    // High for exactly level cycles per period
    assign pwm = count < level;

    assign o_rdata = (i_addr == 4'h0) ? level : '0;
    assign o_pins  = {8{pwm}};

endmodule

// ==== hw/reg_bank_irq.sv ====
/*
 * Register bank for a user slot.
 * Two size-masked data registers, pending flag set by a
 * rising edge on ui_in bit 0 and cleared by a status write.
 */
`timescale 1ns/1ps

module reg_bank_irq
    import tqv_periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [5:0] i_addr,
    input  data_t      i_wdata,
    input  acc_n_t     i_wr_n,
    input  logic       i_ui_in0,
    output data_t      o_rdata,
    output byte_t      o_pins,
    output logic       o_irq
);

    data_t reg0;
    data_t reg1;
    logic  pending;
    logic  ui_d;
    logic  wr;

    // Only the lanes covered by the access size change
    function automatic data_t lane_merge(input data_t cur, input data_t wdata,
                                         input acc_n_t size);
        data_t res;
        res = cur;
        case (size)
            ACC_BYTE: res[7:0]  = wdata[7:0];
            ACC_HALF: res[15:0] = wdata[15:0];
            ACC_WORD: res       = wdata;
            default:  res       = cur;
        endcase
        return res;
    endfunction

    assign wr = i_wr_n != ACC_NONE;

    always_ff @(posedge clk) begin
        if (wr && i_addr == RB_REG0_OFS) reg0 <= lane_merge(reg0, i_wdata, i_wr_n);
        if (wr && i_addr == RB_REG1_OFS) reg1 <= lane_merge(reg1, i_wdata, i_wr_n);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ui_d    <= 1'b0;
            pending <= 1'b0;
        end else begin
            ui_d <= i_ui_in0;
            if (wr && i_addr == RB_STATUS_OFS) pending <= 1'b0;
            if (i_ui_in0 && !ui_d) pending <= 1'b1; // New edge beats the clear
        end
    end

    always_comb begin
        case (i_addr)
            RB_REG0_OFS:   o_rdata = reg0;
            RB_REG1_OFS:   o_rdata = reg1;
            RB_STATUS_OFS: o_rdata = {31'h0, pending};
            default:       o_rdata = '0;
        endcase
    end

    assign o_pins = reg0[7:0];
    assign o_irq  = pending;

endmodule

// ==== hw/tqv_peripherals.sv ====
/*
 * Peripheral wrapper top level.
 * Bus packing, slot decode, read hold, GPIO,
 * PWM audio in a simple slot and register bank in a user slot.
 */
`timescale 1ns/1ps

module tqv_peripherals
    import tqv_periph_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  byte_t    i_ui_in,
    input  addr_t    i_addr,
    input  data_t    i_data_in,
    input  acc_n_t   i_data_write_n,
    input  acc_n_t   i_data_read_n,
    input  logic     i_data_read_complete,
    output data_t    o_data_out,
    output logic     o_data_ready,
    output byte_t    o_uo_out,
    output logic     o_audio,
    output logic     o_audio_select,
    output irq_vec_t o_user_irq
);

    bus_req_t     req;
    peri_rsp_t    rsp;
    user_rsp_t    user_rsp;
    simple_data_t simple_data;
    pin_src_t     user_pins;
    pin_src_t     simple_pins;
    slot_sel_t    user_wr;
    slot_sel_t    user_rd;
    slot_sel_t    simple_wr;
    logic         read_mask;

    data_t gpio_rdata;
    data_t rb_rdata;
    byte_t rb_pins;
    logic  rb_irq;
    byte_t pwm_rdata;
    byte_t pwm_pins;

    assign req = '{addr: i_addr, wdata: i_data_in, write_n: i_data_write_n,
                   read_n: i_data_read_n};

    always_comb begin
        for (int s = 0; s < 16; s++) begin
            user_rsp[s]    = '{data: '0, ready: 1'b1}; // Empty slots read zero
            user_pins[s]   = '0;
            simple_data[s] = '0;
            simple_pins[s] = '0;
        end
        // Populated slots acknowledge their own read strobe
        // and the mask keeps ready up while the data is held
        user_rsp[SLOT_GPIO]    = '{data: gpio_rdata, ready: user_rd[SLOT_GPIO] | read_mask};
        user_rsp[SLOT_REGBANK] = '{data: rb_rdata, ready: user_rd[SLOT_REGBANK] | read_mask};
        user_pins[SLOT_REGBANK]  = rb_pins;
        simple_data[SIMPLE_PWM]  = pwm_rdata;
        simple_pins[SIMPLE_PWM]  = pwm_pins;

        o_user_irq = '0;
        o_user_irq[SLOT_REGBANK - 4'd2] = rb_irq; // Interrupt 15
    end

    assign o_audio = pwm_pins[7];

    peri_addr_decode u_decode (
        .i_req        (req),
        .i_read_mask  (read_mask),
        .i_user_rsp   (user_rsp),
        .i_simple_data(simple_data),
        .o_user_wr    (user_wr),
        .o_user_rd    (user_rd),
        .o_simple_wr  (simple_wr),
        .o_rsp        (rsp)
    );

    peri_read_hold u_hold (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_read_n       (req.read_n),
        .i_write_n      (req.write_n),
        .i_rsp          (rsp),
        .i_read_complete(i_data_read_complete),
        .o_data         (o_data_out),
        .o_ready        (o_data_ready),
        .o_read_mask    (read_mask)
    );

    gpio_ctrl u_gpio (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_addr        (req.addr),
        .i_wdata       (req.wdata),
        .i_wr          (user_wr[SLOT_GPIO]),
        .i_ui_in       (i_ui_in),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_rdata       (gpio_rdata),
        .o_uo_out      (o_uo_out),
        .o_audio_select(o_audio_select)
    );

    pwm_audio u_pwm (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_addr (req.addr[3:0]),
        .i_wdata(req.wdata[7:0]),
        .i_wr   (simple_wr[SIMPLE_PWM]),
        .o_rdata(pwm_rdata),
        .o_pins (pwm_pins)
    );

    reg_bank_irq u_regbank (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_addr  (req.addr[5:0]),
        .i_wdata (req.wdata),
        .i_wr_n  (user_wr[SLOT_REGBANK] ? req.write_n : ACC_NONE),
        .i_ui_in0(i_ui_in[0]),
        .o_rdata (rb_rdata),
        .o_pins  (rb_pins),
        .o_irq   (rb_irq)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_tqv_peripherals -f tqv_peripherals.f \
    -o sim_tqv > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tqv > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// ==== tb/tb_tqv_peripherals.sv ====
/*
 * Testbench top for the peripheral wrapper.
 * Clock, reset, stimulus table and the loop that applies it.
 */
`timescale 1ns/1ps

module tb_tqv_peripherals
    import tqv_periph_pkg::*;
();

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_UI, OP_PINS, OP_AUDIO, OP_IRQ} op_t;

    typedef struct packed {
        op_t        op;
        addr_t      addr;
        data_t      data;
        acc_n_t     size;
        data_t      exp;
        logic [3:0] delay;  // Cycles between ready and read complete
    } entry_t;

    localparam int READY_TIMEOUT = 16;

    logic     clk;
    logic     rst_n;
    byte_t    ui_in;
    addr_t    addr;
    data_t    wdata;
    acc_n_t   write_n;
    acc_n_t   read_n;
    logic     read_complete;
    data_t    data_out;
    logic     data_ready;
    byte_t    uo_out;
    logic     audio;
    logic     audio_select;
    irq_vec_t user_irq;
    logic     hold_watch;
    logic     count_en;
    int       errors;
    logic     timed_out;
    integer   seed;
    entry_t   table_q[$];
    string    name_q[$];

    tqv_peripherals u_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .i_ui_in             (ui_in),
        .i_addr              (addr),
        .i_data_in           (wdata),
        .i_data_write_n      (write_n),
        .i_data_read_n       (read_n),
        .i_data_read_complete(read_complete),
        .o_data_out          (data_out),
        .o_data_ready        (data_ready),
        .o_uo_out            (uo_out),
        .o_audio             (audio),
        .o_audio_select      (audio_select),
        .o_user_irq          (user_irq)
    );

    tqv_checker u_chk (
        .clk           (clk),
        .i_data_out    (data_out),
        .i_data_ready  (data_ready),
        .i_uo_out      (uo_out),
        .i_audio       (audio),
        .i_audio_select(audio_select),
        .i_user_irq    (user_irq),
        .i_hold_watch  (hold_watch),
        .i_count_en    (count_en),
        .o_errors      (errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic addr_t user_addr(input slot_t slot, input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic addr_t simple_addr(input slot_t slot, input logic [3:0] ofs);
        return {1'b1, 2'b00, slot, ofs};
    endfunction

    task automatic add(input string name, input op_t op, input addr_t a, input data_t d,
                       input acc_n_t size, input data_t exp, input int delay);
        name_q.push_back(name);
        table_q.push_back('{op: op, addr: a, data: d, size: size, exp: exp,
                            delay: 4'(delay)});
    endtask

    task automatic build_table();
        data_t w1;
        data_t w2;
        data_t w3;
        data_t merged1;
        data_t merged2;
        byte_t level;
        addr_t gpio_out_a;
        addr_t reg1_a;
        addr_t status_a;
        addr_t pwm_a;
        w1 = $random(seed);
        w2 = $random(seed);
        w3 = $random(seed);
        level = 8'($random(seed));
        merged1 = {w1[31:8], w2[7:0]};       // Byte write touches lane 0 only
        merged2 = {merged1[31:16], w3[15:0]};
        gpio_out_a = user_addr(SLOT_GPIO, GPIO_OUT_OFS);
        reg1_a     = user_addr(SLOT_REGBANK, RB_REG1_OFS);
        status_a   = user_addr(SLOT_REGBANK, RB_STATUS_OFS);
        pwm_a      = simple_addr(SIMPLE_PWM, 4'h0);

        add("irq_after_reset", OP_IRQ, '0, '0, ACC_NONE, 32'h0, 0);
        add("pins_after_reset", OP_PINS, '0, '0, ACC_NONE, 32'h0, 0);
        add("gpio_out_write", OP_WRITE, gpio_out_a, 32'hA5, ACC_WORD, '0, 0);
        add("gpio_out_pins", OP_PINS, '0, '0, ACC_NONE, 32'hA5, 0);
        add("gpio_out_read", OP_READ, gpio_out_a, '0, ACC_WORD, 32'hA5, 0);
        add("ui_drive", OP_UI, '0, 32'h3C, ACC_NONE, '0, 0);
        add("gpio_in_read", OP_READ, user_addr(SLOT_GPIO, GPIO_IN_OFS), '0, ACC_WORD,
            32'h3C, 0);
        add("reg1_word_write", OP_WRITE, reg1_a, w1, ACC_WORD, '0, 0);
        add("reg1_word_read", OP_READ, reg1_a, '0, ACC_WORD, w1, 0);
        add("reg1_byte_write", OP_WRITE, reg1_a, w2, ACC_BYTE, '0, 0);
        add("reg1_byte_read", OP_READ, reg1_a, '0, ACC_WORD, merged1, 0);
        add("reg1_half_write", OP_WRITE, reg1_a, w3, ACC_HALF, '0, 0);
        add("reg1_half_read", OP_READ, reg1_a, '0, ACC_WORD, merged2, 0);

        // Pin 3 to the register bank, pin 4 to simple slot 5
        add("reg0_clear", OP_WRITE, user_addr(SLOT_REGBANK, RB_REG0_OFS), '0, ACC_WORD, '0, 0);
        add("pin3_to_regbank", OP_WRITE, user_addr(SLOT_GPIO, GPIO_FSEL_BASE + 6'd12), 32'h0F,
            ACC_WORD, '0, 0);
        add("pin4_to_pwm", OP_WRITE, user_addr(SLOT_GPIO, GPIO_FSEL_BASE + 6'd16), 32'h15,
            ACC_WORD, '0, 0);
        add("gpio_out_ones", OP_WRITE, gpio_out_a, 32'hFF, ACC_WORD, '0, 0);
        add("pins_routed_low", OP_PINS, '0, '0, ACC_NONE, 32'hE7, 0); // PWM level still 0
        add("reg0_bit3_set", OP_WRITE, user_addr(SLOT_REGBANK, RB_REG0_OFS), 32'h08, ACC_WORD,
            '0, 0);
        add("pins_routed_high", OP_PINS, '0, '0, ACC_NONE, 32'hEF, 0);
        add("fsel3_read", OP_READ, user_addr(SLOT_GPIO, GPIO_FSEL_BASE + 6'd12), '0, ACC_WORD,
            32'h0F, 0);
        add("fsel4_read", OP_READ, user_addr(SLOT_GPIO, GPIO_FSEL_BASE + 6'd16), '0, ACC_WORD,
            32'h15, 0);
        add("empty_user_read", OP_READ, user_addr(4'd7, 6'h00), '0, ACC_WORD, 32'h0, 0);
        add("empty_simple_read", OP_READ, simple_addr(4'd3, 4'h0), '0, ACC_WORD, 32'h0, 0);

        add("pwm_level_write", OP_WRITE, pwm_a, {24'h0, level}, ACC_BYTE, '0, 0);
        add("pwm_level_read", OP_READ, pwm_a, '0, ACC_WORD, {24'h0, level}, 0);
        add("audio_select_write", OP_WRITE, user_addr(SLOT_GPIO, GPIO_AUDIO_OFS), 32'h4,
            ACC_WORD, '0, 0);
        add("audio_select_read", OP_READ, user_addr(SLOT_GPIO, GPIO_AUDIO_OFS), '0, ACC_WORD,
            32'h4, 0);
        // Select flag in bit 16, high cycle count below
        add("audio_count", OP_AUDIO, '0, '0, ACC_NONE, 32'h10000 | {24'h0, level}, 0);

        add("ui_bit0_rise", OP_UI, '0, 32'h3D, ACC_NONE, '0, 0);
        add("irq_set", OP_IRQ, '0, '0, ACC_NONE, 32'h2000, 0);   // Interrupt 15
        add("status_read_held", OP_READ, status_a, '0, ACC_WORD, 32'h1, 5);
        add("status_clear", OP_WRITE, status_a, '0, ACC_WORD, '0, 0);
        add("irq_cleared", OP_IRQ, '0, '0, ACC_NONE, 32'h0, 0);
        add("status_read", OP_READ, status_a, '0, ACC_WORD, 32'h0, 0);
        // Input changes while the read is held, bit 0 stays high
        add("gpio_in_read_held", OP_READ, user_addr(SLOT_GPIO, GPIO_IN_OFS), 32'hC3,
            ACC_WORD, 32'h3D, 5);
    endtask

    task automatic step_to_drive();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_ready(input string name, output logic ok, output int cycles);
        ok     = 1'b0;
        cycles = 0;
        while (cycles < READY_TIMEOUT && !ok) begin
            @(negedge clk);
            cycles++;
            ok = data_ready;
        end
        if (!ok) begin
            $display("Timeout: data ready did not rise within %0d cycles in test %0s",
                     READY_TIMEOUT, name);
            timed_out = 1'b1;
        end
    endtask

    task automatic apply(input string name, input entry_t e);
        logic ok;
        int   cycles;
        step_to_drive();
        case (e.op)
            OP_WRITE: begin
                addr    = e.addr;
                wdata   = e.data;
                write_n = e.size;
                @(negedge clk);                      // Write ready is combinational
                u_chk.check_ready(name);
                step_to_drive();
                write_n = ACC_NONE;
            end
            OP_READ: begin
                addr   = e.addr;
                read_n = e.size;
                wait_ready(name, ok, cycles);
                if (ok) u_chk.check_data(name, e.exp, cycles);
                step_to_drive();
                if (e.delay != 0) begin
                    // Request stays up, data must not move until complete
                    hold_watch = 1'b1;
                    if (e.data != '0) ui_in = e.data[7:0];
                    repeat (e.delay) @(posedge clk);
                    #2;
                    hold_watch = 1'b0;
                end
                read_n        = ACC_NONE;
                read_complete = 1'b1;
                step_to_drive();
                read_complete = 1'b0;
            end
            OP_UI: begin
                ui_in = e.data[7:0];
                u_chk.note(name);
            end
            OP_PINS: begin
                @(negedge clk);
                u_chk.check_pins(name, e.exp);
            end
            OP_AUDIO: begin
                count_en = 1'b1;
                repeat (256) @(posedge clk);         // One full PWM period
                #2;
                count_en = 1'b0;
                u_chk.check_audio(name, e.exp);
            end
            OP_IRQ: begin
                @(negedge clk);
                u_chk.check_irq(name, e.exp);
            end
            default: $display("Unknown operation in test %0s", name);
        endcase
    endtask

    initial begin
        seed          = 32'h11e;
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        wdata         = '0;
        write_n       = ACC_NONE;
        read_n        = ACC_NONE;
        read_complete = 1'b0;
        hold_watch    = 1'b0;
        count_en      = 1'b0;
        timed_out     = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < table_q.size() && !timed_out; i++) begin
            apply(name_q[i], table_q[i]);
        end

        step_to_drive();
        u_chk.summary();
        if (!timed_out && errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb/tqv_checker.sv ====
/*
 * Checker for the peripheral wrapper testbench.
 * Value compares, read latency, held read data watch,
 * PWM high count, result counts.
 */
`timescale 1ns/1ps

module tqv_checker
    import tqv_periph_pkg::*;
(
    input  logic     clk,
    input  data_t    i_data_out,
    input  logic     i_data_ready,
    input  byte_t    i_uo_out,
    input  logic     i_audio,
    input  logic     i_audio_select,
    input  irq_vec_t i_user_irq,
    input  logic     i_hold_watch,
    input  logic     i_count_en,
    output int       o_errors
);

    int    tests = 0;
    int    check_errors = 0;
    int    hold_errors = 0;
    int    high_count = 0;
    int    pin_miss = 0;
    logic  watching = 1'b0;
    data_t held;

    assign o_errors = check_errors + hold_errors;

    // Audio high cycles, and pin 4 must track the same PWM bit
    always @(negedge clk) begin
        if (i_count_en) begin
            high_count <= high_count + int'(i_audio);
            pin_miss   <= pin_miss + int'(i_uo_out[4] != i_audio);
        end else begin
            high_count <= 0;
            pin_miss   <= 0;
        end
    end

    always @(negedge clk) begin
        if (!i_hold_watch) begin
            watching <= 1'b0;
        end else if (!watching) begin
            held     <= i_data_out;             // Reference for the rest of the hold
            watching <= 1'b1;
        end else if (i_data_out !== held) begin
            $display("Held read data changed from %h to %h before the read completed",
                     held, i_data_out);
            hold_errors <= hold_errors + 1;
        end
    end

    task automatic report(input string name, input data_t expected, input data_t actual);
        tests = tests + 1;
        if (actual !== expected) begin
            check_errors = check_errors + 1;
            $display("Error %0s expected %h actual %h", name, expected, actual);
        end else begin
            $display("ok    %0s value %h", name, actual);
        end
    endtask

    task automatic check_ready(input string name);
        report(name, 32'h1, {31'h0, i_data_ready});
    endtask

    // Ready is due on the second falling edge, one clock after the request
    task automatic check_data(input string name, input data_t expected, input int cycles);
        if (cycles != 2) begin
            check_errors = check_errors + 1;
            $display("Read ready came %0d clock edges after the request in test %0s",
                     cycles - 1, name);
        end
        report(name, expected, i_data_out);
    endtask

    task automatic check_pins(input string name, input data_t expected);
        report(name, expected, {23'h0, i_audio_select, i_uo_out});
    endtask

    task automatic check_irq(input string name, input data_t expected);
        report(name, expected, {18'h0, i_user_irq});
    endtask

    task automatic check_audio(input string name, input data_t expected);
        if (pin_miss != 0) begin
            check_errors = check_errors + 1;
            $display("Pin 4 differed from the audio output in %0d cycles of test %0s",
                     pin_miss, name);
        end
        report(name, expected, {15'h0, i_audio_select, 16'(high_count)});
    endtask

    task automatic note(input string name);
        $display("done  %0s", name);
    endtask

    task automatic summary();
        $display("Checks run %0d, failed checks %0d, held data errors %0d",
                 tests, check_errors, hold_errors);
    endtask

endmodule

// ==== tqv_peripherals.f ====
common/tqv_periph_pkg.sv
hw/peri_bus/peri_addr_decode.sv
hw/peri_bus/peri_read_hold.sv
hw/gpio/gpio_ctrl.sv
hw/pwm_audio.sv
hw/reg_bank_irq.sv
hw/tqv_peripherals.sv
tb/tqv_checker.sv
tb/tb_tqv_peripherals.sv
